// ==== src/gauntlet_pkg.sv ====
// Shared widths and the ROM download address map
// Game type codes, joystick, keyboard event and seat select types
// Scan code tables for the Gauntlet and Vindicators Part II key maps
// Four-player game test

package gauntlet_pkg;

	// ##########################################################################
	// Widths and address map
	// ##########################################################################
	localparam int IOCTL_AW     = 25;         // Loader byte address
	localparam int PROG_AW      = 19;         // CPU program word address
	localparam int PROG_BANK_AW = 15;         // 32K words per bank
	localparam int AUDIO_AW     = 15;         // 32 KB audio ROM

	localparam logic [IOCTL_AW-1:0] PROG_A_BASE = 25'h00C0000; // 9A/9B, 64 KB
	localparam logic [IOCTL_AW-1:0] PROG_B_BASE = 25'h0100000; // 7A/7B, 64 KB
	localparam logic [IOCTL_AW-1:0] AUDIO_BASE  = 25'h0140000; // 16S, 32 KB

	// Read address bits 18..15 per bank
	localparam logic [3:0] PROG_A_SEL = 4'd0;
	localparam logic [3:0] PROG_B_SEL = 4'd4;

	localparam logic [15:0] IDX_ROM  = 16'd0; // ROM image
	localparam logic [15:0] IDX_GAME = 16'd1; // Game type byte

	localparam int NUM_PLAYERS = 4;
	localparam int VIND_COINS  = 2;           // Coins 3 and 4 unused in Vindicators

	// ##########################################################################
	// Types
	// ##########################################################################
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;

	typedef enum logic [7:0] {
		GT_GAUNTLET    = 8'd104,
		GT_GAUNTLET2   = 8'd106,
		GT_GAUNTLET_2P = 8'd107,
		GT_VIND2       = 8'd118
	} game_t;

	// MSB first, so right lands in bit 0
	typedef struct packed {
		logic       start;  // Bit 9
		logic       coin;   // Bit 8
		logic [3:0] btn;    // Buttons 4..1
		logic       up;
		logic       down;
		logic       left;
		logic       right;  // Bit 0
	} joy_t;

	typedef logic [1:0] seat_sel_t;           // Joystick offset per seat

	typedef struct packed {
		logic       toggle; // Flips on every event
		logic       pressed;
		logic [8:0] code;   // Bit 8 marks extended codes
	} ps2_key_t;

	// ##########################################################################
	// Scan codes
	// ##########################################################################
	// Gauntlet, indexed by player
	localparam logic [8:0] KG_UP    [NUM_PLAYERS] = '{9'h175, 9'h02D, 9'h043, 9'h075};
	localparam logic [8:0] KG_DOWN  [NUM_PLAYERS] = '{9'h172, 9'h02B, 9'h042, 9'h072};
	localparam logic [8:0] KG_LEFT  [NUM_PLAYERS] = '{9'h16B, 9'h023, 9'h03B, 9'h06B};
	localparam logic [8:0] KG_RIGHT [NUM_PLAYERS] = '{9'h174, 9'h034, 9'h04B, 9'h074};
	localparam logic [8:0] KG_FIRE  [NUM_PLAYERS] = '{9'h014, 9'h01C, 9'h114, 9'h070};
	localparam logic [8:0] KG_MAGIC [NUM_PLAYERS] = '{9'h011, 9'h01B, 9'h059, 9'h071};
	localparam logic [8:0] KC_COIN  [NUM_PLAYERS] = '{9'h02E, 9'h036, 9'h03D, 9'h03E};

	// Vindicators, indexed by port bit: L trig, R trig, L thumb, R thumb, then treads
	localparam logic [8:0] KV_P1 [8] = '{9'h01C, 9'h02B, 9'h015, 9'h02D,
		9'h01D, 9'h024, 9'h01B, 9'h023};
	localparam logic [8:0] KV_P2 [8] = '{9'h033, 9'h04B, 9'h035, 9'h044,
		9'h03C, 9'h043, 9'h03B, 9'h042};
	localparam logic [8:0] KV_START [2] = '{9'h016, 9'h01E}; // Keys 1 and 2

	// Gauntlet and Gauntlet II have four character seats
	function automatic logic is_four_player(game_t gt);
		return (gt == GT_GAUNTLET) || (gt == GT_GAUNTLET2);
	endfunction

endpackage

// ==== src/rom_wr_if.sv ====
// ROM write bus from the download decoder to the memories
// Region strobes, loader address, assembled word and raw byte

`timescale 1ns/1ps

interface rom_wr_if;
	import gauntlet_pkg::*;

	logic                prog_a_wr; // One-cycle strobes
	logic                prog_b_wr;
	logic                audio_wr;
	logic [IOCTL_AW-1:0] wr_addr;   // Byte address as sent by the host
	word_t               wr_word;   // Previous byte in the high half
	byte_t               wr_byte;

	modport loader (
		output prog_a_wr, prog_b_wr, audio_wr, wr_addr, wr_word, wr_byte
	);

	modport mem (
		input prog_a_wr, prog_b_wr, audio_wr, wr_addr, wr_word, wr_byte
	);

endinterface

// ==== src/rom_loader.sv ====
// ROM download decoder
// Byte pair accumulator for the program banks, region decode,
// registered write strobes and the game type register

`timescale 1ns/1ps

module rom_loader (
	input  logic                                 clk_sys,
	input  logic                                 rst,
	input  logic                                 ioctl_download,
	input  logic                                 ioctl_wr,
	input  logic [15:0]                          ioctl_index,
	input  logic [gauntlet_pkg::IOCTL_AW-1:0]    ioctl_addr,
	input  gauntlet_pkg::byte_t                  ioctl_dout,
	rom_wr_if.loader                             wr,
	output gauntlet_pkg::game_t                  game_type
);
	import gauntlet_pkg::*;

	logic  accept;                   // Valid ROM byte this cycle
	logic  in_prog_a, in_prog_b;     // 64 KB regions
	logic  in_audio;                 // 32 KB region
	byte_t prev_byte;                // High byte of the next word

	assign accept = ioctl_wr && ioctl_download && (ioctl_index == IDX_ROM);

	// Region match on the bits above the region size
	assign in_prog_a = ioctl_addr[IOCTL_AW-1:16] == PROG_A_BASE[IOCTL_AW-1:16];
	assign in_prog_b = ioctl_addr[IOCTL_AW-1:16] == PROG_B_BASE[IOCTL_AW-1:16];
	assign in_audio  = ioctl_addr[IOCTL_AW-1:15] == AUDIO_BASE[IOCTL_AW-1:15];

	// Every accepted byte shifts in whatever the region
	always_ff @(posedge clk_sys) begin
		if (accept) prev_byte <= ioctl_dout;
	end

	// ##########################################################################
	// Write stage towards the memories
	// ##########################################################################
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr.prog_a_wr <= 1'b0;
			wr.prog_b_wr <= 1'b0;
			wr.audio_wr  <= 1'b0;
		end else begin
			wr.prog_a_wr <= accept && in_prog_a && ioctl_addr[0]; // Odd byte closes a word
			wr.prog_b_wr <= accept && in_prog_b && ioctl_addr[0];
			wr.audio_wr  <= accept && in_audio;                   // Every audio byte is written
		end
	end

	// Payload registered alongside the strobes
	always_ff @(posedge clk_sys) begin
		wr.wr_addr <= ioctl_addr;
		wr.wr_word <= {prev_byte, ioctl_dout}; // prev_byte still holds the even byte
		wr.wr_byte <= ioctl_dout;
	end

	// Game type byte from index 1 writes
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			game_type <= GT_GAUNTLET;
		end else if (ioctl_wr && (ioctl_index == IDX_GAME)) begin
			game_type <= game_t'(ioctl_dout);
		end
	end

endmodule

// ==== src/rom_bank.sv ====
// Simple dual-port ROM image memory
// Write port from the loader, one registered read port,
// payload type set per instance

`timescale 1ns/1ps

module rom_bank #(
	parameter int  AW        = 15,
	parameter type payload_t = gauntlet_pkg::byte_t
) (
	input  logic          clk_sys,
	input  logic          wr_en,
	input  logic [AW-1:0] wr_addr,
	input  payload_t      wr_data,
	input  logic [AW-1:0] rd_addr,
	output payload_t      rd_data
);

	payload_t mem [2**AW]; // Block RAM

	always_ff @(posedge clk_sys) begin
		if (wr_en) mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];     // Data one cycle after address
	end

endmodule

// ==== src/program_rom.sv ====
// CPU program ROM, banks 9A/9B and 7A/7B
// Bank decode registered next to the memory read,
// unmapped space reads as zero

`timescale 1ns/1ps

module program_rom (
	input  logic                               clk_sys,
	rom_wr_if.mem                              wr,
	input  logic [gauntlet_pkg::PROG_AW-1:0]   rd_addr,
	output gauntlet_pkg::word_t                rd_data
);
	import gauntlet_pkg::*;

	word_t      data_a, data_b;
	logic [3:0] bank_hi;          // Read address bits 18..15
	logic       sel_a_q, sel_b_q; // Aligned with the memory output

	assign bank_hi = rd_addr[PROG_AW-1:PROG_BANK_AW];

	always_ff @(posedge clk_sys) begin
		sel_a_q <= bank_hi == PROG_A_SEL;
		sel_b_q <= bank_hi == PROG_B_SEL;
	end

	// Word address is the byte address without bit 0
	rom_bank #(.AW(PROG_BANK_AW), .payload_t(word_t)) bank_a_i (
		.clk_sys (clk_sys),
		.wr_en   (wr.prog_a_wr),
		.wr_addr (wr.wr_addr[PROG_BANK_AW:1]),
		.wr_data (wr.wr_word),
		.rd_addr (rd_addr[PROG_BANK_AW-1:0]),
		.rd_data (data_a)
	);

	rom_bank #(.AW(PROG_BANK_AW), .payload_t(word_t)) bank_b_i (
		.clk_sys (clk_sys),
		.wr_en   (wr.prog_b_wr),
		.wr_addr (wr.wr_addr[PROG_BANK_AW:1]),
		.wr_data (wr.wr_word),
		.rd_addr (rd_addr[PROG_BANK_AW-1:0]),
		.rd_data (data_b)
	);

	assign rd_data = sel_a_q ? data_a :
	                 sel_b_q ? data_b :
	                 '0;              // Fallthrough for dropped banks

endmodule

// ==== src/key_decoder.sv ====
// Keyboard event decoder
// Input register and toggle edge detect, then the Gauntlet or
// Vindicators map into held key bits per player and coin bits

`timescale 1ns/1ps

module key_decoder (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  gauntlet_pkg::ps2_key_t   ps2_key,
	input  gauntlet_pkg::game_t      game_type,
	output gauntlet_pkg::byte_t      key_p [gauntlet_pkg::NUM_PLAYERS],
	output logic [3:0]               key_coin
);
	import gauntlet_pkg::*;

	ps2_key_t ev_q;   // Registered event
	logic     tog_q;  // Toggle seen one cycle earlier

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ev_q     <= '0;
			tog_q    <= 1'b0;
			key_p    <= '{default: '0};
			key_coin <= '0;
		end else begin
			ev_q  <= ps2_key;
			tog_q <= ev_q.toggle;

			if (ev_q.toggle != tog_q) begin // New event
				if (game_type == GT_VIND2) begin
					// Tank sticks on P1 and P2, all eight bits
					for (int b = 0; b < 8; b++) begin
						if (ev_q.code == KV_P1[b]) key_p[0][b] <= ev_q.pressed;
						if (ev_q.code == KV_P2[b]) key_p[1][b] <= ev_q.pressed;
					end
					for (int s = 0; s < 2; s++) begin
						if (ev_q.code == KV_START[s]) key_p[2][s] <= ev_q.pressed; // Starts in P3
					end
					for (int c = 0; c < VIND_COINS; c++) begin
						if (ev_q.code == KC_COIN[c]) key_coin[c] <= ev_q.pressed;
					end
				end else begin
					// Gauntlet layout, same bits for every player
					for (int p = 0; p < NUM_PLAYERS; p++) begin
						if (ev_q.code == KG_UP[p])    key_p[p][7] <= ev_q.pressed;
						if (ev_q.code == KG_DOWN[p])  key_p[p][6] <= ev_q.pressed;
						if (ev_q.code == KG_LEFT[p])  key_p[p][5] <= ev_q.pressed;
						if (ev_q.code == KG_RIGHT[p]) key_p[p][4] <= ev_q.pressed;
						if (ev_q.code == KG_FIRE[p])  key_p[p][1] <= ev_q.pressed;
						if (ev_q.code == KG_MAGIC[p]) key_p[p][0] <= ev_q.pressed;
						if (ev_q.code == KC_COIN[p])  key_coin[p] <= ev_q.pressed;
					end
				end
			end
		end
	end

endmodule

// ==== src/seat_router.sv ====
// Joystick to character seat routing
// Per-seat rotating offset in four-player games, identity otherwise

`timescale 1ns/1ps

module seat_router (
	input  gauntlet_pkg::joy_t      joy_in   [gauntlet_pkg::NUM_PLAYERS],
	input  gauntlet_pkg::seat_sel_t seat_sel [gauntlet_pkg::NUM_PLAYERS],
	input  gauntlet_pkg::game_t     game_type,
	output gauntlet_pkg::joy_t      joy_seat [gauntlet_pkg::NUM_PLAYERS]
);
	import gauntlet_pkg::*;

	always_comb begin
		seat_sel_t src; // Wraps mod 4 on its own
		for (int k = 0; k < NUM_PLAYERS; k++) begin
			src = seat_sel_t'(k) + seat_sel[k];
			if (is_four_player(game_type)) begin
				joy_seat[k] = joy_in[src];
			end else begin
				joy_seat[k] = joy_in[k];  // Two-player and Vindicators
			end
		end
	end

endmodule

// ==== src/port_encoder.sv ====
// Player and system port encoder
// Registered tank tread conversion for seats 0 and 1,
// active-low player bytes per game and the system byte

`timescale 1ns/1ps

module port_encoder (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  gauntlet_pkg::joy_t     joy_seat [gauntlet_pkg::NUM_PLAYERS],
	input  gauntlet_pkg::byte_t    key_p    [gauntlet_pkg::NUM_PLAYERS],
	input  logic [3:0]             key_coin,
	input  logic                   service,
	input  gauntlet_pkg::game_t    game_type,
	output gauntlet_pkg::byte_t    port_p   [gauntlet_pkg::NUM_PLAYERS],
	output logic [4:0]             sys_in
);
	import gauntlet_pkg::*;

	logic [3:0] tread_q [2]; // {X back, W back, X fwd, W fwd}
	logic       vind;

	// Stick to tread table
	function automatic logic [3:0] tread_of(joy_t j);
		case ({j.up, j.down, j.left, j.right})
			4'b1000: tread_of = 4'b0011; // Up, both forward
			4'b0100: tread_of = 4'b1100; // Down, both back
			4'b0010: tread_of = 4'b0110; // Left, W back X fwd
			4'b0001: tread_of = 4'b1001; // Right, W fwd X back
			4'b1010: tread_of = 4'b0010; // Up-left
			4'b1001: tread_of = 4'b0001; // Up-right
			4'b0101: tread_of = 4'b0100; // Down-right
			4'b0110: tread_of = 4'b1000; // Down-left
			default: tread_of = 4'b0000; // Centre or odd combos
		endcase
	endfunction

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			tread_q <= '{default: '0};
		end else begin
			for (int s = 0; s < 2; s++) tread_q[s] <= tread_of(joy_seat[s]);
		end
	end

	assign vind = game_type == GT_VIND2;

	// ##########################################################################
	// Player bytes, key OR stick, inverted
	// ##########################################################################
	always_comb begin
		for (int k = 0; k < NUM_PLAYERS; k++) begin
			port_p[k] = ~(key_p[k] | {joy_seat[k].up, joy_seat[k].down,
				joy_seat[k].left, joy_seat[k].right, joy_seat[k].btn});
		end
		if (vind) begin
			port_p[0] = ~(key_p[0] | {tread_q[0], joy_seat[0].btn});
			port_p[1] = ~(key_p[1] | {tread_q[1], joy_seat[1].btn});
			port_p[2] = ~(key_p[2] | {6'b0, joy_seat[1].start, joy_seat[0].start});
			port_p[3] = ~key_p[3];  // Keys only
		end
	end

	// Service in bit 4, then coins for seats 0..3
	assign sys_in = {~service,
	                 ~(key_coin[0] | joy_seat[0].coin),
	                 ~(key_coin[1] | joy_seat[1].coin),
	                 ~(key_coin[2] | joy_seat[2].coin),
	                 ~(key_coin[3] | joy_seat[3].coin)};

endmodule

// ==== src/gauntlet_io_top.sv ====
// Gauntlet I/O top level
// ROM download decoder, program and audio ROMs,
// keyboard decoder, seat routing and port encoding

`timescale 1ns/1ps

module gauntlet_io_top (
	input  logic                                clk_sys,
	input  logic                                rst,
	input  logic                                ioctl_download,
	input  logic                                ioctl_wr,
	input  logic [15:0]                         ioctl_index,
	input  logic [gauntlet_pkg::IOCTL_AW-1:0]   ioctl_addr,
	input  gauntlet_pkg::byte_t                 ioctl_dout,
	input  logic [gauntlet_pkg::PROG_AW-1:0]    prog_addr,
	output gauntlet_pkg::word_t                 prog_data,
	input  logic [gauntlet_pkg::AUDIO_AW-1:0]   audio_addr,
	output gauntlet_pkg::byte_t                 audio_data,
	input  gauntlet_pkg::ps2_key_t              ps2_key,
	input  gauntlet_pkg::joy_t                  joy0,
	input  gauntlet_pkg::joy_t                  joy1,
	input  gauntlet_pkg::joy_t                  joy2,
	input  gauntlet_pkg::joy_t                  joy3,
	input  gauntlet_pkg::seat_sel_t             seat0_sel,
	input  gauntlet_pkg::seat_sel_t             seat1_sel,
	input  gauntlet_pkg::seat_sel_t             seat2_sel,
	input  gauntlet_pkg::seat_sel_t             seat3_sel,
	input  logic                                service,
	output gauntlet_pkg::byte_t                 port_p1,
	output gauntlet_pkg::byte_t                 port_p2,
	output gauntlet_pkg::byte_t                 port_p3,
	output gauntlet_pkg::byte_t                 port_p4,
	output logic [4:0]                          sys_in
);
	import gauntlet_pkg::*;

	rom_wr_if  rom_wr ();
	game_t     game_type;
	joy_t      joy_in   [NUM_PLAYERS];
	seat_sel_t seat_sel [NUM_PLAYERS];
	joy_t      joy_seat [NUM_PLAYERS];
	byte_t     key_p    [NUM_PLAYERS];
	logic [3:0] key_coin;
	byte_t     port_p   [NUM_PLAYERS];

	// Flat ports to arrays and back
	assign joy_in[0]   = joy0;
	assign joy_in[1]   = joy1;
	assign joy_in[2]   = joy2;
	assign joy_in[3]   = joy3;
	assign seat_sel[0] = seat0_sel;
	assign seat_sel[1] = seat1_sel;
	assign seat_sel[2] = seat2_sel;
	assign seat_sel[3] = seat3_sel;
	assign port_p1     = port_p[0];
	assign port_p2     = port_p[1];
	assign port_p3     = port_p[2];
	assign port_p4     = port_p[3];

	// ##########################################################################
	// ROM download and read
	// ##########################################################################
	rom_loader loader_i (
		.clk_sys, .rst, .ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr,
		.ioctl_dout, .wr(rom_wr.loader), .game_type
	);

	program_rom prog_i (
		.clk_sys, .wr(rom_wr.mem), .rd_addr(prog_addr), .rd_data(prog_data)
	);

	rom_bank #(.AW(AUDIO_AW), .payload_t(byte_t)) audio_i ( // 16S
		.clk_sys, .wr_en(rom_wr.audio_wr), .wr_addr(rom_wr.wr_addr[AUDIO_AW-1:0]),
		.wr_data(rom_wr.wr_byte), .rd_addr(audio_addr), .rd_data(audio_data)
	);

	// ##########################################################################
	// Player inputs
	// ##########################################################################
	key_decoder keys_i (
		.clk_sys, .rst, .ps2_key, .game_type, .key_p, .key_coin
	);

	seat_router seats_i (
		.joy_in, .seat_sel, .game_type, .joy_seat
	);

	port_encoder ports_i (
		.clk_sys, .rst, .joy_seat, .key_p, .key_coin, .service, .game_type,
		.port_p, .sys_in
	);

endmodule

// ==== dv/tb_gauntlet_io.sv ====
// Testbench for the Gauntlet I/O top level
// ROM download and read-back, Gauntlet key map, seat routing,
// Vindicators treads and keys, service input and reset
// Reference functions give expected values, a negedge process compares

`timescale 1ns/1ps

module tb_gauntlet_io;
	import gauntlet_pkg::*;

	typedef enum int {CHK_NONE, CHK_PORTS, CHK_PROG, CHK_AUDIO} chk_t;

	logic                clk_sys;
	logic                rst;
	logic                ioctl_download;
	logic                ioctl_wr;
	logic [15:0]         ioctl_index;
	logic [IOCTL_AW-1:0] ioctl_addr;
	byte_t               ioctl_dout;
	logic [PROG_AW-1:0]  prog_addr;
	word_t               prog_data;
	logic [AUDIO_AW-1:0] audio_addr;
	byte_t               audio_data;
	ps2_key_t            ps2_key;
	joy_t                joy [4];
	seat_sel_t           sel [4];
	logic                service;
	byte_t               port_p1, port_p2, port_p3, port_p4;
	logic [4:0]          sys_in;

	byte_t              img [int];  // Downloaded bytes by loader address
	byte_t              mk [4];     // Held key bits per player
	logic [3:0]         mcoin;      // Held coin keys
	game_t              mg;         // Game type the host last sent
	logic               key_tgl;
	int                 seed;
	chk_t               chk_kind;
	string              test_name;
	logic [PROG_AW-1:0] chk_addr;   // Address whose data is due now
	logic [PROG_AW-1:0] rq [$];     // Read-back list

	gauntlet_io_top dut_i (
		.clk_sys, .rst, .ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.prog_addr, .prog_data, .audio_addr, .audio_data, .ps2_key,
		.joy0(joy[0]), .joy1(joy[1]), .joy2(joy[2]), .joy3(joy[3]),
		.seat0_sel(sel[0]), .seat1_sel(sel[1]), .seat2_sel(sel[2]), .seat3_sel(sel[3]),
		.service, .port_p1, .port_p2, .port_p3, .port_p4, .sys_in
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	// ##########################################################################
	// Reference model
	// ##########################################################################
	function automatic word_t exp_prog(logic [PROG_AW-1:0] a);
		int ba;
		if (a[18:15] == PROG_A_SEL) ba = int'(PROG_A_BASE);
		else if (a[18:15] == PROG_B_SEL) ba = int'(PROG_B_BASE);
		else return 16'h0000;           // Unmapped
		ba = ba + 2 * int'(a[14:0]);
		return {img[ba], img[ba + 1]};  // Even byte high
	endfunction

	function automatic byte_t exp_audio(logic [PROG_AW-1:0] a);
		return img[int'(AUDIO_BASE) + int'(a[AUDIO_AW-1:0])];
	endfunction

	// Stick feeding seat k
	function automatic joy_t seat_joy(int k);
		if (mg == GT_GAUNTLET || mg == GT_GAUNTLET2) return joy[(k + int'(sel[k])) % 4];
		return joy[k];
	endfunction

	// Tread bits {X back, W back, X fwd, W fwd}, one term per tread
	function automatic logic [3:0] tread_ref(joy_t j);
		logic [3:0] d;
		logic       wf, xf, wb, xb;
		d  = {j.up, j.down, j.left, j.right};
		wf = (d == 4'b1000) || (d == 4'b0001) || (d == 4'b1001); // Up, right, up-right
		xf = (d == 4'b1000) || (d == 4'b0010) || (d == 4'b1010); // Up, left, up-left
		wb = (d == 4'b0100) || (d == 4'b0010) || (d == 4'b0101); // Down, left, down-right
		xb = (d == 4'b0100) || (d == 4'b0001) || (d == 4'b0110); // Down, right, down-left
		return {xb, wb, xf, wf};
	endfunction

	function automatic byte_t exp_port(int k);
		joy_t  j, j0, j1;
		byte_t stick;
		j     = seat_joy(k);
		j0    = seat_joy(0);
		j1    = seat_joy(1);
		stick = {j.up, j.down, j.left, j.right, j.btn};
		if (mg == GT_VIND2) begin
			case (k)
				0, 1:    stick = {tread_ref(j), j.btn};
				2:       stick = {6'b0, j1.start, j0.start}; // Starts only
				default: stick = 8'h00;
			endcase
		end
		return ~(mk[k] | stick);
	endfunction

	function automatic logic [4:0] exp_sys();
		logic [4:0] s;
		joy_t       j;
		s[4] = ~service;
		for (int k = 0; k < 4; k++) begin
			j      = seat_joy(k);
			s[3-k] = ~(mcoin[k] | j.coin); // Seat 0 in bit 3
		end
		return s;
	endfunction

	// ##########################################################################
	// Compare process
	// ##########################################################################
	task automatic compare_value(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		assert (act === exp) else begin
			$display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		case (chk_kind)
			CHK_PORTS: begin
				compare_value("port_p1", 16'(exp_port(0)), 16'(port_p1));
				compare_value("port_p2", 16'(exp_port(1)), 16'(port_p2));
				compare_value("port_p3", 16'(exp_port(2)), 16'(port_p3));
				compare_value("port_p4", 16'(exp_port(3)), 16'(port_p4));
				compare_value("sys_in", 16'(exp_sys()), 16'(sys_in));
			end
			CHK_PROG:  compare_value("prog_data", exp_prog(chk_addr), prog_data);
			CHK_AUDIO: compare_value("audio_data", 16'(exp_audio(chk_addr)), 16'(audio_data));
			default: ;
		endcase
	end

	// ##########################################################################
	// Stimulus tasks
	// ##########################################################################
	task automatic settle();
		repeat (4) @(posedge clk_sys); // Input paths settle within 3 cycles
	endtask

	task automatic check_ports(input string name);
		@(posedge clk_sys);
		test_name = name;
		chk_kind <= CHK_PORTS;
		@(posedge clk_sys);
		chk_kind <= CHK_NONE;
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		rst     <= 1'b1;
		ps2_key <= '0;     // No stale event after reset
		key_tgl = 1'b0;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;
		mk    = '{default: '0};
		mcoin = '0;
		mg    = GT_GAUNTLET;
	endtask

	// One loader byte, strobe every other cycle
	task automatic drive_byte(input logic [15:0] idx, input logic [IOCTL_AW-1:0] a,
		input byte_t d);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_wr       <= 1'b1;
		ioctl_index    <= idx;
		ioctl_addr     <= a;
		ioctl_dout     <= d;
		if (idx == IDX_ROM) img[int'(a)] = d;
		else if (idx == IDX_GAME) mg = game_t'(d);
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	task automatic load_block(input logic [IOCTL_AW-1:0] base, input int off, input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = $random(seed);
			drive_byte(IDX_ROM, base + IOCTL_AW'(off + i), r[7:0]);
		end
		ioctl_download <= 1'b0;
	endtask

	task automatic set_game(input game_t gt);
		drive_byte(IDX_GAME, '0, byte_t'(gt));
		ioctl_download <= 1'b0;
		settle();
	endtask

	// New address every cycle, data checked one cycle later
	task automatic read_back(input chk_t kind, input string name);
		test_name = name;
		for (int i = 0; i <= rq.size(); i++) begin
			@(posedge clk_sys);
			if (i < rq.size()) begin
				prog_addr  <= rq[i];
				audio_addr <= rq[i][AUDIO_AW-1:0];
			end
			if (i > 0) begin
				chk_addr <= rq[i-1];
				chk_kind <= kind;
			end
		end
		@(posedge clk_sys);
		chk_kind <= CHK_NONE;
	endtask

	task automatic key_check(input logic [8:0] code, input logic pr, input string name);
		@(posedge clk_sys);
		key_tgl = ~key_tgl;
		ps2_key <= ps2_key_t'({key_tgl, pr, code});
		settle();
		check_ports(name);
	endtask

	// ##########################################################################
	// Tests
	// ##########################################################################
	task automatic test_prog_rom();
		logic [31:0] r;
		int          off_a, off_b;
		r     = $random(seed);
		off_a = int'(r[15:0]) & 'hFF80;
		off_b = int'(r[31:16]) & 'hFF80;
		load_block(PROG_A_BASE, off_a, 64);
		load_block(PROG_A_BASE, 'hFFF0, 16); // Top of the bank
		load_block(PROG_B_BASE, off_b, 64);
		load_block(PROG_B_BASE, 'hFFF0, 16);
		rq.delete();
		rq.push_back({4'd2, r[14:0]});       // Unmapped
		for (int i = 0; i < 32; i++) begin
			rq.push_back({PROG_A_SEL, 15'((off_a >> 1) + i)});
			rq.push_back({PROG_B_SEL, 15'((off_b >> 1) + i)}); // Alternate banks
		end
		for (int i = 0; i < 8; i++) begin
			rq.push_back({PROG_B_SEL, 15'h7FF8 + 15'(i)});
			rq.push_back({PROG_A_SEL, 15'h7FF8 + 15'(i)});
		end
		rq.push_back({4'd1, r[30:16]});
		rq.push_back({4'd15, r[14:0]});
		read_back(CHK_PROG, "prog_rom");
	endtask

	task automatic test_audio_rom();
		logic [31:0] r;
		int          off;
		r   = $random(seed);
		off = int'(r[14:0]) & 'h7F00;
		load_block(AUDIO_BASE, off, 48);
		load_block(AUDIO_BASE, 'h7FF0, 16);
		// Game index bytes over the same addresses, no ROM write
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			drive_byte(IDX_GAME, AUDIO_BASE + IOCTL_AW'(off + i), r[7:0]);
		end
		set_game(GT_GAUNTLET);
		rq.delete();
		for (int i = 0; i < 48; i++) rq.push_back(PROG_AW'(off + i));
		for (int i = 0; i < 16; i++) rq.push_back(PROG_AW'('h7FF0 + i));
		read_back(CHK_AUDIO, "audio_rom");
	endtask

	task automatic test_gauntlet_keys();
		logic [8:0] codes [6];
		int         bits [6];
		logic       pr;
		bits = '{7, 6, 5, 4, 1, 0};  // Up, down, left, right, fire, magic
		for (int n = 0; n < 2; n++) begin
			pr = (n == 0);           // Press all, then release all
			for (int p = 0; p < 4; p++) begin
				codes = '{KG_UP[p], KG_DOWN[p], KG_LEFT[p], KG_RIGHT[p], KG_FIRE[p], KG_MAGIC[p]};
				for (int f = 0; f < 6; f++) begin
					mk[p][bits[f]] = pr;
					key_check(codes[f], pr, "gauntlet_keys");
				end
				mcoin[p] = pr;
				key_check(KC_COIN[p], pr, "gauntlet_coin");
			end
		end
	endtask

	task automatic random_sticks(input string name, input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			for (int k = 0; k < 4; k++) begin
				r = $random(seed);
				joy[k] <= joy_t'(r[9:0]);
				sel[k] <= seat_sel_t'(r[11:10]);
			end
			settle();
			check_ports(name);
		end
	endtask

	task automatic test_vind();
		logic [31:0] r;
		logic [3:0]  pos [9];
		joy_t        j0, j1;
		logic        pr;
		pos = '{4'b0000, 4'b1000, 4'b0100, 4'b0010, 4'b0001,
			4'b1010, 4'b1001, 4'b0101, 4'b0110};  // {up, down, left, right}
		set_game(GT_VIND2);
		for (int i = 0; i < 9; i++) begin
			@(posedge clk_sys);
			r  = $random(seed);
			j0 = joy_t'(r[9:0]);
			j1 = joy_t'(r[19:10]);
			{j0.up, j0.down, j0.left, j0.right} = pos[i];
			{j1.up, j1.down, j1.left, j1.right} = pos[(i + 4) % 9];
			joy[0] <= j0;
			joy[1] <= j1;
			joy[2] <= joy_t'(r[29:20]);
			joy[3] <= joy_t'({r[31:30], r[7:0]}); // Must not reach P4
			settle();
			check_ports("vind_treads");
		end
		for (int n = 0; n < 2; n++) begin
			pr = (n == 0);
			for (int b = 0; b < 8; b++) begin
				mk[0][b] = pr;
				key_check(KV_P1[b], pr, "vind_keys");
				mk[1][b] = pr;
				key_check(KV_P2[b], pr, "vind_keys");
			end
			for (int s = 0; s < 2; s++) begin
				mk[2][s] = pr;
				key_check(KV_START[s], pr, "vind_start");
				mcoin[s] = pr;
				key_check(KC_COIN[s], pr, "vind_coin");
			end
			key_check(KG_UP[3], pr, "vind_p4");   // Unmapped here
		end
	endtask

	task automatic test_service_reset();
		@(posedge clk_sys);
		service <= 1'b1;
		settle();
		check_ports("service");
		@(posedge clk_sys);
		service <= 1'b0;
		joy     <= '{default: '0};
		set_game(GT_GAUNTLET);
		check_ports("service");
		// Held keys and coins clear on reset
		mk[0][7] = 1'b1;
		key_check(KG_UP[0], 1'b1, "held_keys");
		mcoin[2] = 1'b1;
		key_check(KC_COIN[2], 1'b1, "held_keys");
		apply_reset();
		check_ports("reset_held");
	endtask

	initial begin
		rst            = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		prog_addr      = '0;
		audio_addr     = '0;
		ps2_key        = '0;
		joy            = '{default: '0};
		sel            = '{default: '0};
		service        = 1'b0;
		key_tgl        = 1'b0;
		seed           = 32'h9eb8;
		chk_kind       = CHK_NONE;
		chk_addr       = '0;
		test_name      = "reset";
		mk             = '{default: '0};
		mcoin          = '0;
		mg             = GT_GAUNTLET;

		apply_reset();
		check_ports("reset");
		test_prog_rom();
		test_audio_rom();
		test_gauntlet_keys();
		random_sticks("seat_routing", 24);
		set_game(GT_GAUNTLET2);
		random_sticks("seat_routing_g2", 8);
		set_game(GT_GAUNTLET_2P);
		random_sticks("seat_identity", 16);
		test_vind();
		test_service_reset();

		$display("sim passed");
		$finish;
	end

endmodule

// ==== gauntlet_io_top.f ====
src/gauntlet_pkg.sv
src/rom_wr_if.sv
src/rom_loader.sv
src/rom_bank.sv
src/program_rom.sv
src/key_decoder.sv
src/seat_router.sv
src/port_encoder.sv
src/gauntlet_io_top.sv
dv/tb_gauntlet_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build tb_gauntlet_io with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
	verilator --binary --assert -j 0 --top-module tb_gauntlet_io \
		-f gauntlet_io_top.f -o tb_gauntlet_io &&
	./obj_dir/tb_gauntlet_io ||
	exit 1
